//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

   typedef logic [7:0] mem_addr_t;
   typedef logic [1:0] port_idx_t;

   localparam int mem_size = 256;
   localparam int num_ports = 4;

   // port k is mapped at port_base + k.
   localparam mem_addr_t port_base = 8'd128;

   // nibble address of the first instruction in the upper half of byte 4.
   localparam logic [7:0] boot_pc = 8'h08;
   localparam mem_addr_t stack_top = 8'hff;    // stack grows down.

   localparam string mem_image = "prog.hex";

endpackage

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   typedef logic [7:0] word_t;
   typedef logic [7:0] nibble_pc_t;    // bits 7:1 address a byte, bit 0 picks the half.
   typedef logic [1:0] reg_sel_t;

   // codes 8, 9 and 15 fall through as a no-op.
   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_mul  = 4'd2,
      op_nand = 4'd3,
      op_sw01 = 4'd4,
      op_sw12 = 4'd5,
      op_sw23 = 4'd6,
      op_be   = 4'd7,
      op_pop  = 4'd10,
      op_push = 4'd11,
      op_ldw  = 4'd12,
      op_stw  = 4'd13,
      op_ref  = 4'd14
   } opcode_t;

   typedef enum logic [3:0] {
      boot_0, boot_1, boot_2, boot_3, boot_4,
      fetch, decode, exec_1, exec_2, exec_3
   } cpu_state_t;

   typedef enum logic {wb_result, wb_mem} wb_src_t;

   typedef enum logic [4:0] {
      res_zero, res_one, res_two, res_three, res_pc_byte, res_pc_inc,
      res_add, res_sub, res_mul, res_nand, res_x01, res_x12, res_x23,
      res_sp, res_sp_inc, res_sp_dec, res_r2, res_r3
   } result_sel_t;

   localparam word_t word_reset = 8'h00;
   localparam opcode_t ir_reset = op_add;

endpackage

`default_nettype wire

//--- logic/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
   input  logic                 clk,
   input  logic                 nRst,
   input  cpu_pkg::opcode_t     opcode,
   input  logic                 equal,
   output logic                 ir_load,
   output logic                 pc_load,
   output logic                 sp_load,
   output logic                 reg_we,
   output cpu_pkg::reg_sel_t    reg_sel,
   output cpu_pkg::wb_src_t     from_mem,
   output logic                 addr_load,
   output logic                 store,
   output cpu_pkg::result_sel_t result_sel
);
   import cpu_pkg::*;

   cpu_state_t  state;
   cpu_state_t  state_next;
   logic        is_swap;
   reg_sel_t    swap_lo;
   result_sel_t swap_res;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= boot_0;
      end else begin
         state <= state_next;
      end
   end

   // lower register of the swap pair and the xor that goes with it.
   always_comb begin
      is_swap  = 1'b1;
      swap_lo  = 2'd0;
      swap_res = res_x01;
      case (opcode)
         op_sw01: swap_res = res_x01;
         op_sw12: begin
            swap_lo  = 2'd1;
            swap_res = res_x12;
         end
         op_sw23: begin
            swap_lo  = 2'd2;
            swap_res = res_x23;
         end
         default: is_swap = 1'b0;
      endcase
   end

   always_comb begin
      state_next = fetch;
      case (state)
         boot_0: state_next = boot_1;
         boot_1: state_next = boot_2;
         boot_2: state_next = boot_3;
         boot_3: state_next = boot_4;
         fetch:  state_next = decode;
         decode: state_next = exec_1;
         exec_1: if (is_swap || opcode inside {op_pop, op_push, op_ldw, op_stw, op_ref}) begin
            state_next = exec_2;
         end
         exec_2: if (is_swap || opcode == op_push) begin
            state_next = exec_3;
         end
         default: state_next = fetch;
      endcase
   end

   always_comb begin
      ir_load    = 1'b0;
      pc_load    = 1'b0;
      sp_load    = 1'b0;
      reg_we     = 1'b0;
      reg_sel    = 2'd0;
      from_mem   = wb_result;
      addr_load  = 1'b0;
      store      = 1'b0;
      result_sel = res_zero;
      case (state)
         boot_0: addr_load = 1'b1;
         boot_1, boot_2, boot_3, boot_4: begin    // each boot cycle takes the byte addressed before it.
            addr_load = 1'b1;
            reg_we    = 1'b1;
            from_mem  = wb_mem;
            case (state)
               boot_1: result_sel = res_one;
               boot_2: begin
                  result_sel = res_two;
                  reg_sel    = 2'd1;
               end
               boot_3: begin
                  result_sel = res_three;
                  reg_sel    = 2'd2;
               end
               default: begin
                  result_sel = res_pc_byte;
                  reg_sel    = 2'd3;
               end
            endcase
         end
         fetch: begin
            result_sel = res_pc_byte;
            addr_load  = 1'b1;
         end
         decode: begin
            result_sel = res_pc_inc;
            ir_load    = 1'b1;
            pc_load    = 1'b1;
         end
         exec_1: begin
            case (opcode)
               op_add:  reg_we = 1'b1;
               op_sub:  reg_we = 1'b1;
               op_mul:  reg_we = 1'b1;
               op_nand: reg_we = 1'b1;
               op_be:   pc_load = equal;    // branch target is held in r3.
               op_pop:  sp_load = 1'b1;
               default: ;
            endcase
            case (opcode)
               op_add:  result_sel = res_add;
               op_sub:  result_sel = res_sub;
               op_mul:  result_sel = res_mul;
               op_nand: result_sel = res_nand;
               op_be, op_ldw, op_stw: result_sel = res_r3;
               op_pop:  result_sel = res_sp_inc;
               op_push: result_sel = res_sp;
               default: result_sel = res_zero;
            endcase
            addr_load = opcode inside {op_pop, op_push, op_ldw, op_stw, op_ref};
         end
         exec_2: begin
            case (opcode)
               op_push: begin
                  result_sel = res_sp_dec;
                  sp_load    = 1'b1;
               end
               op_pop, op_ldw, op_ref: begin
                  reg_we   = 1'b1;
                  reg_sel  = (opcode == op_ref) ? 2'd0 : 2'd2;
                  from_mem = wb_mem;
               end
               op_stw: begin
                  result_sel = res_r2;
                  store      = 1'b1;
               end
               default: ;
            endcase
         end
         exec_3: if (opcode == op_push) begin
            result_sel = res_r2;
            store      = 1'b1;
         end
         default: ;
      endcase
      // of the three xor steps only the middle one writes the upper register.
      if (is_swap && state inside {exec_1, exec_2, exec_3}) begin
         result_sel = swap_res;
         reg_we     = 1'b1;
         reg_sel    = (state == exec_2) ? swap_lo + 2'd1 : swap_lo;
      end
   end

endmodule

`default_nettype wire

//--- logic/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
   input  logic                 clk,
   input  logic                 nRst,
   input  logic                 ir_load,
   input  logic                 pc_load,
   input  logic                 sp_load,
   input  logic                 reg_we,
   input  cpu_pkg::reg_sel_t    reg_sel,
   input  cpu_pkg::wb_src_t     from_mem,
   input  logic                 addr_load,
   input  cpu_pkg::result_sel_t result_sel,
   input  cpu_pkg::word_t       rd_data,
   output mem_pkg::mem_addr_t   addr,
   output cpu_pkg::word_t       wr_data,
   output cpu_pkg::opcode_t     opcode,
   output logic                 equal
);
   import cpu_pkg::*;
   import mem_pkg::*;

   word_t      r [4];
   word_t      sp;
   nibble_pc_t pc;
   word_t      result;
   word_t      wb_data;

   assign equal   = (r[1] == r[2]);
   assign wr_data = result;    // stores always take r2 through the result word.
   assign wb_data = (from_mem == wb_mem) ? rd_data : result;

   always_comb begin
      case (result_sel)
         res_one:     result = 8'd1;
         res_two:     result = 8'd2;
         res_three:   result = 8'd3;
         res_pc_byte: result = {1'b0, pc[7:1]};
         res_pc_inc:  result = pc + 8'd1;
         res_add:     result = r[1] + r[2];
         res_sub:     result = r[1] - r[2];
         res_mul:     result = r[1] * r[2];    // low byte only.
         res_nand:    result = ~(r[1] & r[2]);
         res_x01:     result = r[0] ^ r[1];
         res_x12:     result = r[1] ^ r[2];
         res_x23:     result = r[2] ^ r[3];
         res_sp:      result = sp;
         res_sp_inc:  result = sp + 8'd1;
         res_sp_dec:  result = sp - 8'd1;
         res_r2:      result = r[2];
         res_r3:      result = r[3];
         default:     result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         for (int i = 0; i < 4; i++) begin
            r[i] <= word_reset;
         end
         sp     <= stack_top;
         pc     <= boot_pc;
         opcode <= ir_reset;
         addr   <= word_reset;
      end else begin
         if (reg_we) begin
            r[reg_sel] <= wb_data;
         end
         if (sp_load) begin
            sp <= result;
         end
         if (pc_load) begin
            pc <= result;
         end
         if (ir_load) begin
            opcode <= opcode_t'(pc[0] ? rd_data[3:0] : rd_data[7:4]);    // odd pc takes the low nibble.
         end
         if (addr_load) begin
            addr <= result;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/io_ports.sv
`timescale 1ns/1ns
`default_nettype none

module io_ports (
   input  logic               clk,
   input  logic               nRst,
   input  logic               port_strobe_0,
   input  logic               port_strobe_1,
   input  logic               port_strobe_2,
   input  logic               port_strobe_3,
   input  cpu_pkg::word_t     port_data_0,
   input  cpu_pkg::word_t     port_data_1,
   input  cpu_pkg::word_t     port_data_2,
   input  cpu_pkg::word_t     port_data_3,
   input  logic               grant,
   output logic               req,
   output mem_pkg::port_idx_t req_port,
   output cpu_pkg::word_t     req_data
);
   import cpu_pkg::*;
   import mem_pkg::*;

   logic [num_ports-1:0] strobe;
   logic [num_ports-1:0] pending;
   word_t                data_in   [num_ports];
   word_t                pend_data [num_ports];

   assign strobe     = {port_strobe_3, port_strobe_2, port_strobe_1, port_strobe_0};
   assign data_in[0] = port_data_0;
   assign data_in[1] = port_data_1;
   assign data_in[2] = port_data_2;
   assign data_in[3] = port_data_3;

   // lowest pending port wins.
   always_comb begin
      req_port = '0;
      for (int k = num_ports - 1; k >= 0; k--) begin
         if (pending[k]) begin
            req_port = port_idx_t'(k);
         end
      end
   end

   assign req      = |pending;
   assign req_data = pend_data[req_port];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pending <= '0;
      end else begin
         for (int k = 0; k < num_ports; k++) begin
            if (strobe[k]) begin
               pending[k] <= 1'b1;    // a fresh word keeps the request up.
            end else if (grant && req_port == port_idx_t'(k)) begin
               pending[k] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < num_ports; k++) begin
         if (strobe[k]) begin
            pend_data[k] <= data_in[k];
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/shared_memory.sv
`timescale 1ns/1ns
`default_nettype none

module shared_memory (
   input  logic               clk,
   input  mem_pkg::mem_addr_t addr,
   output cpu_pkg::word_t     rd_data,
   input  logic               cpu_store,
   input  cpu_pkg::word_t     cpu_data,
   input  logic               port_req,
   input  mem_pkg::port_idx_t port_idx,
   input  cpu_pkg::word_t     port_data,
   output logic               port_grant,
   output cpu_pkg::word_t     port_out_0,
   output cpu_pkg::word_t     port_out_1,
   output cpu_pkg::word_t     port_out_2,
   output cpu_pkg::word_t     port_out_3
);
   import cpu_pkg::*;
   import mem_pkg::*;

   word_t     mem [mem_size];
   mem_addr_t port_addr;
   mem_addr_t wr_addr;
   word_t     wr_data;
   logic      wr_en;

   initial begin
      $readmemh(mem_image, mem);
   end

   // the core cannot stall, so a port only gets a free cycle.
   assign port_grant = port_req & ~cpu_store;
   assign port_addr  = port_base + mem_addr_t'(port_idx);
   assign wr_en      = cpu_store | port_req;
   assign wr_addr    = cpu_store ? addr : port_addr;
   assign wr_data    = cpu_store ? cpu_data : port_data;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   assign rd_data    = mem[addr];
   assign port_out_0 = mem[port_base];
   assign port_out_1 = mem[port_base + 8'd1];
   assign port_out_2 = mem[port_base + 8'd2];
   assign port_out_3 = mem[port_base + 8'd3];

endmodule

`default_nettype wire

//--- logic/up_system.sv
`timescale 1ns/1ns
`default_nettype none

module up_system (
   input  logic           clk,
   input  logic           nRst,
   input  logic           port_strobe_0,
   input  logic           port_strobe_1,
   input  logic           port_strobe_2,
   input  logic           port_strobe_3,
   input  cpu_pkg::word_t port_data_0,
   input  cpu_pkg::word_t port_data_1,
   input  cpu_pkg::word_t port_data_2,
   input  cpu_pkg::word_t port_data_3,
   output cpu_pkg::word_t port_out_0,
   output cpu_pkg::word_t port_out_1,
   output cpu_pkg::word_t port_out_2,
   output cpu_pkg::word_t port_out_3
);
   import cpu_pkg::*;
   import mem_pkg::*;

   logic        ir_load;
   logic        pc_load;
   logic        sp_load;
   logic        reg_we;
   reg_sel_t    reg_sel;
   wb_src_t     from_mem;
   logic        addr_load;
   logic        store;
   result_sel_t result_sel;
   opcode_t     opcode;
   logic        equal;
   mem_addr_t   addr;
   word_t       rd_data;
   word_t       wr_data;
   logic        req;
   logic        grant;
   port_idx_t   req_port;
   word_t       req_data;

   control_unit control_unit_i (.*);

   datapath datapath_i (.*);

   io_ports io_ports_i (.*);

   shared_memory shared_memory_i (
      .clk        (clk),
      .addr       (addr),
      .rd_data    (rd_data),
      .cpu_store  (store),
      .cpu_data   (wr_data),
      .port_req   (req),
      .port_idx   (req_port),
      .port_data  (req_data),
      .port_grant (grant),
      .port_out_0 (port_out_0),
      .port_out_1 (port_out_1),
      .port_out_2 (port_out_2),
      .port_out_3 (port_out_3)
   );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int period_ns    = 10,
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic nRst
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   initial begin
      nRst = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1 nRst = 1'b1;    // release just after an edge.
   end

endmodule

`default_nettype wire

//--- tests/tb_up_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_up_system;
   import cpu_pkg::*;
   import mem_pkg::*;

   localparam int clk_period   = 10;
   localparam int num_pairs    = 16;
   localparam int land_limit   = 5;
   localparam int pass_limit   = 700;    // one program pass is 266 cycles.
   localparam int hold_cycles  = 300;
   localparam int burst_rounds = 100;
   localparam int run_cycles   = num_pairs * (pass_limit + hold_cycles + 2 * land_limit)
                                 + (1 + 2 * land_limit) * burst_rounds + 1000;

   logic        clk;
   logic        nRst;
   logic        port_strobe_0;
   logic        port_strobe_1;
   logic        port_strobe_2;
   logic        port_strobe_3;
   word_t       port_data_0;
   word_t       port_data_1;
   word_t       port_data_2;
   word_t       port_data_3;
   word_t       port_out_0;
   word_t       port_out_1;
   word_t       port_out_2;
   word_t       port_out_3;
   logic [31:0] rng_state;

   tb_clock #(.period_ns(clk_period), .reset_cycles(4)) tb_clock_i (.clk(clk), .nRst(nRst));

   up_system up_system_i (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t sum_rule(input word_t a, input word_t b);
      return a + b;
   endfunction

   // nand of the low bytes of a*b and a-b.
   function automatic word_t nand_rule(input word_t a, input word_t b);
      word_t prod;
      word_t diff;
      prod = a * b;
      diff = a - b;
      return ~(prod & diff);
   endfunction

   function automatic word_t port_value(input int idx);
      case (idx)
         0:       return port_out_0;
         1:       return port_out_1;
         2:       return port_out_2;
         default: return port_out_3;
      endcase
   endfunction

   task automatic report_error(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1, "stopping at the first failed check");
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic random_word(output word_t w);
      rng_state = xorshift32(rng_state);
      w = rng_state[7:0];
   endtask

   task automatic strobe_ports(input logic s0, input logic s1, input word_t d0, input word_t d1);
      port_strobe_0 = s0;
      port_strobe_1 = s1;
      port_data_0   = d0;
      port_data_1   = d1;
      next_cycle();
      port_strobe_0 = 1'b0;
      port_strobe_1 = 1'b0;
   endtask

   task automatic wait_for_port(input int idx, input word_t expected, input int limit);
      int n;
      n = 0;
      while (port_value(idx) != expected && n < limit) begin
         next_cycle();
         n++;
      end
      assert (port_value(idx) == expected)
         else report_error($sformatf("port_out_%0d is %02h, expected %02h within %0d cycles",
                                     idx, port_value(idx), expected, limit));
   endtask

   task automatic check_pair(input word_t a, input word_t b);
      word_t exp_sum;
      word_t exp_nand;
      int    n;
      exp_sum  = sum_rule(a, b);
      exp_nand = nand_rule(a, b);
      strobe_ports(1'b1, 1'b1, a, b);
      wait_for_port(0, a, land_limit);
      wait_for_port(1, b, land_limit);
      n = 0;
      while (!(port_out_2 == exp_sum && port_out_3 == exp_nand) && n < pass_limit) begin
         next_cycle();
         n++;
      end
      assert (port_out_2 == exp_sum && port_out_3 == exp_nand)
         else report_error($sformatf("a=%02h b=%02h gave %02h/%02h, expected %02h/%02h",
                                     a, b, port_out_2, port_out_3, exp_sum, exp_nand));
      // the loop keeps rewriting the same results.
      repeat (hold_cycles) begin
         next_cycle();
         assert (port_out_0 == a && port_out_1 == b && port_out_2 == exp_sum
                 && port_out_3 == exp_nand)
            else report_error($sformatf("results for a=%02h b=%02h did not hold", a, b));
      end
   endtask

   initial begin
      word_t a;
      word_t b;
      word_t w;
      word_t last_0;
      word_t last_1;
      port_strobe_0 = 1'b0;
      port_strobe_1 = 1'b0;
      port_strobe_2 = 1'b0;
      port_strobe_3 = 1'b0;
      port_data_0   = '0;
      port_data_1   = '0;
      port_data_2   = '0;
      port_data_3   = '0;
      rng_state     = 32'h55614aaa;
      last_0        = '0;
      last_1        = '0;
      @(posedge nRst);
      next_cycle();

      assert (port_out_0 == 8'h00 && port_out_1 == 8'h00 && port_out_2 == 8'h00
              && port_out_3 == 8'h00)
         else report_error("mapped outputs are not the image values after reset");

      random_word(w);
      strobe_ports(1'b1, 1'b0, w, 8'h00);
      wait_for_port(0, w, land_limit);
      repeat (20) begin
         next_cycle();
         assert (port_out_0 == w)
            else report_error($sformatf("port_out_0 moved to %02h, expected %02h", port_out_0, w));
      end

      for (int i = 0; i < num_pairs; i++) begin
         random_word(a);
         random_word(b);
         check_pair(a, b);
      end

      // both ports together for more than one pass so that some writes meet a store.
      for (int i = 0; i < burst_rounds; i++) begin
         random_word(last_0);
         random_word(last_1);
         strobe_ports(1'b1, 1'b1, last_0, last_1);
         wait_for_port(0, last_0, land_limit);
         wait_for_port(1, last_1, land_limit);
      end

      $display("Result: PASSED");
      $finish;
   end

   initial begin
      #(run_cycles * clk_period);
      $display("Result: FAILED");
      $fatal(1, "watchdog timeout, the test did not finish within %0d cycles", run_cycles);
   end

endmodule

`default_nettype wire

//--- prog.hex
// one byte per word; bytes 0..3 load r0..r3 at boot, code starts at byte 4
@00
01 80 80 80
// init: push 128 for the loop, then branch to nibble 128
B7
// main loop at nibble 128, reads 128/129 and writes 130/131
@40
CB E4 60 45 6C 5A 50 45
B5 42 45 B5 41 4A 34 5E
46 04 56 5A D5 E4 60 45
6D AB 6A B5 AB 78
// mapped ports start at zero
@80
00 00 00 00

//--- tb.f
logic/mem_pkg.sv
logic/cpu_pkg.sv
logic/control_unit.sv
logic/datapath.sv
logic/io_ports.sv
logic/shared_memory.sv
logic/up_system.sv
tests/tb_clock.sv
tests/tb_up_system.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_up_system -f tb.f \
   && ./obj_dir/Vtb_up_system \
   || exit 1
